// File: gcm_cfg_pkg.sv
//--------------------
// Width and latency constants for the
// AES-GCM control plane
//--------------------

package gcm_cfg_pkg;

    //--------------------
    // Widths
    //--------------------
    // Length and word counters
    localparam int NB_TIMER       = 10;
    // One AES / GHASH block
    localparam int NB_BLOCK       = 128;
    // Initialization vector
    localparam int NB_IV          = 96;
    // Low counter field of a GCTR block, inc32 domain
    localparam int NB_CTR         = NB_BLOCK - NB_IV;
    // Each half of the GHASH length word
    localparam int NB_LEN_FIELD   = NB_BLOCK / 2;
    // Words to bits, one block is 2^7 bits
    localparam int NB_BLOCK_SHIFT = $clog2(NB_BLOCK);
    // GHASH kind encoding
    localparam int NB_KIND        = 2;

    //--------------------
    // Timing
    //--------------------
    // Enabled cycles through the AES pipeline
    localparam int AES_LATENCY    = 44;

    // inc32(J0), first counter used for data
    localparam logic [NB_CTR-1:0] CTR_FIRST = 2;

endpackage

// File: gcm_ctr_block_gen.sv
//--------------------
// GCTR counter blocks from the IV:
// J0 + 1 on load, inc32 per advance
//--------------------

`timescale 1ns/1ps

module gcm_ctr_block_gen
    import gcm_cfg_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_enable,
    input  logic [NB_IV-1:0]    i_iv,
    input  logic                i_load,
    input  logic                i_advance,
    output logic [NB_BLOCK-1:0] o_ctr_block
);

    //--------------------
    // Internal signals
    //--------------------
    logic [NB_BLOCK-1:0] ctr_block_q;
    logic [NB_CTR-1:0]   load_low;
    logic [NB_CTR-1:0]   inc_low;

    // Word taken in the load cycle already uses counter 2
    assign load_low = CTR_FIRST + NB_CTR'(i_advance);

    // inc32, wraps in the low field only
    assign inc_low = ctr_block_q[NB_CTR-1:0] + 1'b1;

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            ctr_block_q <= '0;
        end
        else if (i_enable)
        begin
            // New packet: IV || 2
            if (i_load)
                ctr_block_q <= {i_iv, load_low};
            else if (i_advance)
                ctr_block_q <= {ctr_block_q[NB_BLOCK-1:NB_CTR], inc_low};
        end
    end

    assign o_ctr_block = ctr_block_q;

endmodule

// File: gcm_ctrl_checker.sv
//--------------------
// Assertions on the sequencing FSM strobes
//--------------------

`timescale 1ns/1ps

module gcm_ctrl_checker
    import gcm_types_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_rst,
    input  logic          i_enable,
    input  logic          i_sop,
    input  ghash_strobe_t i_strobe,
    input  logic          i_data_sop
);

    int   assert_errors = 0;
    logic fired_q;
    logic new_pkt;

    assign new_pkt = i_enable & i_sop;

    // Data sop already seen in this packet
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            fired_q <= 1'b0;
        else if (new_pkt)
            fired_q <= i_data_sop;
        else if (i_data_sop)
            fired_q <= 1'b1;
    end

    strobes_exclusive: assert property (@(posedge i_clock) disable iff (i_rst)
        $onehot0({i_strobe.valid_aad, i_strobe.valid_data, i_strobe.valid_length}))
    else
    begin
        $error("GHASH valid strobes overlap");
        assert_errors++;
    end

    data_sop_once: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_data_sop && !new_pkt) |-> !fired_q)
    else
    begin
        $error("data sop fired twice in one packet");
        assert_errors++;
    end

    idle_in_reset: assert property (@(posedge i_clock)
        i_rst |-> !(i_strobe.valid_aad || i_strobe.valid_data || i_strobe.valid_length))
    else
    begin
        $error("GHASH strobe valid during reset");
        assert_errors++;
    end

endmodule

// File: gcm_ctrl_monitor.sv
//--------------------
// Reference model and output compare
// for the GCM control top
//--------------------

`timescale 1ns/1ps

module gcm_ctrl_monitor
    import gcm_cfg_pkg::*;
    import gcm_types_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_enable,
    input  logic                i_sop,
    input  logic                i_valid_encrypt,
    input  logic                i_valid_decrypt,
    input  logic                i_encrypt_mode,
    input  logic                i_trigger_pre_block,
    input  logic [NB_TIMER-1:0] i_length_aad,
    input  logic [NB_TIMER-1:0] i_length_plaintext,
    input  logic [NB_BLOCK-1:0] i_word,
    input  logic [NB_IV-1:0]    i_iv,
    input  ghash_word_t         i_ghash,
    input  gctr_mark_t          i_gctr_mark,
    input  logic [NB_BLOCK-1:0] i_ctr_block,
    input  logic [NB_TIMER-1:0] i_exp_aad,
    input  logic [NB_TIMER-1:0] i_exp_data,
    input  logic [NB_BLOCK-1:0] i_exp_len_word,
    output int                  o_errors,
    output int                  o_packets
);

    //--------------------
    // Model state
    //--------------------
    ghash_word_t         exp_ghash;
    logic [NB_BLOCK-1:0] exp_ctr;
    // Marks of the last AES_LATENCY enabled cycles, oldest first
    gctr_mark_t          mark_q [$];
    logic [NB_TIMER-1:0] la;
    logic [NB_TIMER-1:0] lp;
    logic                mode;
    logic                active;
    logic                aad_over;
    logic                pre_done;
    logic                sop_done;
    logic                len_pend;
    int                  aad_cnt;
    int                  dat_cnt;
    int                  aad_seen;
    int                  dat_seen;

    task report_mismatch(input string name, input logic [NB_BLOCK-1:0] got,
                         input logic [NB_BLOCK-1:0] exp);
        $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        o_errors++;
    endtask

    task clear_model;
        mark_q.delete();
        repeat (AES_LATENCY) mark_q.push_back(gctr_mark_t'(0));
        exp_ghash = '0;
        exp_ctr   = '0;
        la        = '0;
        lp        = '0;
        mode      = 1'b0;
        active    = 1'b0;
        aad_over  = 1'b0;
        pre_done  = 1'b0;
        sop_done  = 1'b0;
        len_pend  = 1'b0;
        aad_cnt   = 0;
        dat_cnt   = 0;
        aad_seen  = 0;
        dat_seen  = 0;
        o_errors  = 0;
        o_packets = 0;
    endtask

    // Registered outputs against last cycle's prediction
    task compare_outputs;
        if (i_ghash.valid !== exp_ghash.valid)
            report_mismatch("o_ghash.valid", i_ghash.valid, exp_ghash.valid);
        if (i_ghash.sop !== exp_ghash.sop)
            report_mismatch("o_ghash.sop", i_ghash.sop, exp_ghash.sop);
        if (i_ghash.kind !== exp_ghash.kind)
            report_mismatch("o_ghash.kind", i_ghash.kind, exp_ghash.kind);
        if (exp_ghash.valid && i_ghash.data !== exp_ghash.data)
            report_mismatch("o_ghash.data", i_ghash.data, exp_ghash.data);
        if (i_gctr_mark !== mark_q[0])
            report_mismatch("o_gctr_mark", i_gctr_mark, mark_q[0]);
        if (i_ctr_block !== exp_ctr)
            report_mismatch("o_ctr_block", i_ctr_block, exp_ctr);
        if (i_ghash.valid && i_ghash.kind == AAD)
            aad_seen++;
        if (i_ghash.valid && i_ghash.kind == DATA)
            dat_seen++;
        // LEN word closes the packet, compare with the table
        if (i_ghash.valid && i_ghash.kind == LEN)
        begin
            if (aad_seen != i_exp_aad)
                report_mismatch("AAD word count", aad_seen, i_exp_aad);
            if (dat_seen != i_exp_data)
                report_mismatch("DATA word count", dat_seen, i_exp_data);
            if (i_ghash.data !== i_exp_len_word)
                report_mismatch("o_ghash.data length word", i_ghash.data, i_exp_len_word);
            aad_seen = 0;
            dat_seen = 0;
            o_packets++;
        end
    endtask

    // Expected strobes for this cycle's inputs
    task predict_next;
        logic       en;
        logic       trig;
        logic       data_in;
        logic       pre;
        logic       is_aad;
        logic       is_data;
        logic       is_len;
        logic       data_sop;
        gctr_mark_t mark_now;
        en   = i_enable;
        trig = en & i_trigger_pre_block;
        if (en && i_sop)
        begin
            la       = i_length_aad;
            lp       = i_length_plaintext;
            mode     = i_encrypt_mode;
            aad_cnt  = 0;
            dat_cnt  = 0;
            active   = 1'b1;
            aad_over = (i_length_aad == 0);
            pre_done = 1'b0;
            sop_done = 1'b0;
            len_pend = 1'b0;
        end
        data_in  = mode ? i_valid_encrypt : i_valid_decrypt;
        // Pre strobe in the enabled cycle after the last AAD word
        pre      = en & active & aad_over & ~pre_done;
        is_aad   = en && active && i_valid_decrypt && (aad_cnt < la);
        is_data  = en && active && data_in && (aad_cnt == la) && (dat_cnt < lp);
        is_len   = en && active && ((lp == 0) ? pre : len_pend);
        data_sop = is_data & ~sop_done;

        exp_ghash.sop   = en & i_sop;
        exp_ghash.valid = is_aad | is_data | is_len;
        exp_ghash.data  = i_word;
        exp_ghash.kind  = NONE;
        if (is_len)
        begin
            exp_ghash.kind = LEN;
            // Bit lengths, 128 bits per word
            exp_ghash.data = {NB_LEN_FIELD'(la) * NB_BLOCK, NB_LEN_FIELD'(lp) * NB_BLOCK};
        end
        else if (is_aad)
            exp_ghash.kind = AAD;
        else if (is_data)
            exp_ghash.kind = DATA;

        // Counter block: IV with 2, then inc32
        if (en && pre)
            exp_ctr = {i_iv, NB_CTR'(2) + NB_CTR'(i_valid_encrypt)};
        else if (en && i_valid_encrypt)
            exp_ctr[NB_CTR-1:0] = exp_ctr[NB_CTR-1:0] + 1'b1;

        mark_now.sop_pre       = pre | trig;
        mark_now.sop           = data_sop;
        mark_now.triggered_pre = trig;
        if (en)
        begin
            void'(mark_q.pop_front());
            mark_q.push_back(mark_now);
        end

        if (is_aad)
        begin
            aad_cnt++;
            if (aad_cnt == la)
                aad_over = 1'b1;
        end
        if (is_data)
        begin
            dat_cnt++;
            if (dat_cnt == lp)
                len_pend = 1'b1;
        end
        pre_done = pre_done | pre;
        sop_done = sop_done | data_sop;
        if (is_len)
        begin
            active   = 1'b0;
            len_pend = 1'b0;
        end
    endtask

    // Inputs and outputs are both settled at the falling edge
    always @(negedge i_clock)
    begin
        if (i_rst)
            clear_model();
        else
        begin
            compare_outputs();
            predict_next();
        end
    end

endmodule

// File: gcm_ctrl_top.f
gcm_cfg_pkg.sv
gcm_types_pkg.sv
gcm_seq_fsm.sv
gcm_delay_line.sv
gcm_ctr_block_gen.sv
gcm_ghash_input_sel.sv
gcm_ctrl_top.sv
gcm_ctrl_checker.sv
gcm_ctrl_monitor.sv
tb_gcm_ctrl_top.sv

// File: gcm_ctrl_top.sv
//--------------------
// GCM control plane top: FSM, AES latency line,
// counter generator and GHASH selector
//--------------------

`timescale 1ns/1ps

module gcm_ctrl_top
    import gcm_cfg_pkg::*;
    import gcm_types_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_enable,
    input  logic                i_sop,
    input  logic                i_valid_encrypt,
    input  logic                i_valid_decrypt,
    input  logic                i_encrypt_mode,
    input  logic                i_trigger_pre_block,
    input  logic [NB_TIMER-1:0] i_length_aad,
    input  logic [NB_TIMER-1:0] i_length_plaintext,
    input  logic [NB_BLOCK-1:0] i_word,
    input  logic [NB_IV-1:0]    i_iv,
    output ghash_word_t         o_ghash,
    output gctr_mark_t          o_gctr_mark,
    output logic [NB_BLOCK-1:0] o_ctr_block
);

    //--------------------
    // Interconnect
    //--------------------
    ghash_strobe_t fsm_strobe;
    gctr_mark_t    fsm_mark;
    logic          data_sop;

    gcm_seq_fsm u_seq_fsm
    (
        .i_clock             (i_clock),
        .i_rst               (i_rst),
        .i_enable            (i_enable),
        .i_sop               (i_sop),
        .i_valid_encrypt     (i_valid_encrypt),
        .i_valid_decrypt     (i_valid_decrypt),
        .i_encrypt_mode      (i_encrypt_mode),
        .i_trigger_pre_block (i_trigger_pre_block),
        .i_length_aad        (i_length_aad),
        .i_length_plaintext  (i_length_plaintext),
        .o_strobe            (fsm_strobe),
        .o_mark              (fsm_mark),
        .o_data_sop          (data_sop)
    );

    // GCTR marks shifted by the AES pipeline depth
    gcm_delay_line #(.T_PAYLOAD(gctr_mark_t)) u_mark_delay
    (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_enable (i_enable),
        .i_data   (fsm_mark),
        .o_data   (o_gctr_mark)
    );

    // Loaded at data sop, stepped per encrypt word
    gcm_ctr_block_gen u_ctr_block_gen
    (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_enable    (i_enable),
        .i_iv        (i_iv),
        .i_load      (data_sop),
        .i_advance   (i_valid_encrypt),
        .o_ctr_block (o_ctr_block)
    );

    gcm_ghash_input_sel u_ghash_input_sel
    (
        .i_clock            (i_clock),
        .i_rst              (i_rst),
        .i_strobe           (fsm_strobe),
        .i_word             (i_word),
        .i_length_aad       (i_length_aad),
        .i_length_plaintext (i_length_plaintext),
        .o_ghash            (o_ghash)
    );

endmodule

// File: gcm_delay_line.sv
//--------------------
// Fixed AES-latency shift line, any payload type
//--------------------

`timescale 1ns/1ps

module gcm_delay_line
    import gcm_cfg_pkg::*;
#(
    parameter type T_PAYLOAD = logic
)
(
    input  logic     i_clock,
    input  logic     i_rst,
    input  logic     i_enable,
    input  T_PAYLOAD i_data,
    output T_PAYLOAD o_data
);

    // One stage per enabled AES cycle
    T_PAYLOAD line_q [AES_LATENCY];

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < AES_LATENCY; i++)
            begin
                line_q[i] <= '0;
            end
        end
        else if (i_enable)
        begin
            line_q[0] <= i_data;
            // Shift toward the output
            for (int i = 1; i < AES_LATENCY; i++)
            begin
                line_q[i] <= line_q[i-1];
            end
        end
        // Low enable holds every stage
    end

    // Oldest stage
    assign o_data = line_q[AES_LATENCY-1];

endmodule

// File: gcm_ghash_input_sel.sv
//--------------------
// GHASH operand select and register
//--------------------

`timescale 1ns/1ps

module gcm_ghash_input_sel
    import gcm_cfg_pkg::*;
    import gcm_types_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  ghash_strobe_t       i_strobe,
    input  logic [NB_BLOCK-1:0] i_word,
    input  logic [NB_TIMER-1:0] i_length_aad,
    input  logic [NB_TIMER-1:0] i_length_plaintext,
    output ghash_word_t         o_ghash
);

    //--------------------
    // Internal signals
    //--------------------
    logic [NB_LEN_FIELD-1:0] aad_bits;
    logic [NB_LEN_FIELD-1:0] ptx_bits;
    ghash_word_t             ghash_d;
    ghash_word_t             ghash_q;

    // Block counts to bit counts, 64 bits each
    assign aad_bits = {{(NB_LEN_FIELD-NB_TIMER-NB_BLOCK_SHIFT){1'b0}},
                       i_length_aad, {NB_BLOCK_SHIFT{1'b0}}};
    assign ptx_bits = {{(NB_LEN_FIELD-NB_TIMER-NB_BLOCK_SHIFT){1'b0}},
                       i_length_plaintext, {NB_BLOCK_SHIFT{1'b0}}};

    // Priority LEN, AAD, DATA
    always_comb
    begin
        ghash_d.sop   = i_strobe.sop;
        ghash_d.valid = i_strobe.valid_length | i_strobe.valid_aad | i_strobe.valid_data;
        ghash_d.kind  = NONE;
        ghash_d.data  = i_word;
        if (i_strobe.valid_length)
        begin
            ghash_d.kind = LEN;
            ghash_d.data = {aad_bits, ptx_bits};
        end
        else if (i_strobe.valid_aad)
            ghash_d.kind = AAD;
        else if (i_strobe.valid_data)
            ghash_d.kind = DATA;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            ghash_q <= '0;
        else
            ghash_q <= ghash_d;
    end

    assign o_ghash = ghash_q;

endmodule

// File: gcm_seq_fsm.sv
//--------------------
// Packet sequencing FSM: word counters,
// GHASH valid strobes and GCTR sop marks
//--------------------

`timescale 1ns/1ps

module gcm_seq_fsm
    import gcm_cfg_pkg::*;
    import gcm_types_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_enable,
    input  logic                i_sop,
    input  logic                i_valid_encrypt,
    input  logic                i_valid_decrypt,
    input  logic                i_encrypt_mode,
    input  logic                i_trigger_pre_block,
    input  logic [NB_TIMER-1:0] i_length_aad,
    input  logic [NB_TIMER-1:0] i_length_plaintext,
    output ghash_strobe_t       o_strobe,
    output gctr_mark_t          o_mark,
    output logic                o_data_sop
);

    //--------------------
    // Internal signals
    //--------------------
    logic                en_sop;
    logic                data_in;
    logic [1:0]          fsm_case;
    logic [NB_TIMER:0]   total_len;
    logic [NB_TIMER-1:0] word_cnt_q;
    logic [NB_TIMER-1:0] word_cnt;
    logic [NB_TIMER:0]   word_cnt_nx;
    logic [NB_TIMER-1:0] ciph_cnt_q;
    logic [NB_TIMER-1:0] ciph_cnt;
    logic [NB_TIMER:0]   ciph_cnt_nx;
    logic                open_q;
    logic                pkt_open;
    logic                aad_done_q;
    logic                aad_done;
    logic                pre_fired_q;
    logic                pre_fired;
    logic                sop_fired_q;
    logic                sop_fired;
    logic                len_pend_q;
    logic                len_pend;
    logic                aad_left;
    logic                valid_aad;
    logic                valid_data;
    logic                ciph_inc;
    logic                last_aad;
    logic                last_data;
    logic                aad_complete;
    logic                close_on_pre;
    logic                data_allowed;
    logic                sop_pre;
    logic                data_sop;
    logic                valid_length;
    logic                trig;

    //--------------------
    // Counters and flags as seen this cycle
    //--------------------
    // A qualified sop clears everything for the new packet
    assign en_sop    = i_enable & i_sop;
    assign pkt_open  = en_sop | open_q;
    assign word_cnt  = en_sop ? '0 : word_cnt_q;
    assign ciph_cnt  = en_sop ? '0 : ciph_cnt_q;
    assign aad_done  = en_sop ? 1'b0 : aad_done_q;
    assign pre_fired = en_sop ? 1'b0 : pre_fired_q;
    assign sop_fired = en_sop ? 1'b0 : sop_fired_q;
    assign len_pend  = en_sop ? 1'b0 : len_pend_q;

    // One extra bit so AAD plus data cannot wrap
    assign total_len   = {1'b0, i_length_aad} + {1'b0, i_length_plaintext};
    assign word_cnt_nx = {1'b0, word_cnt} + 1'b1;
    assign ciph_cnt_nx = {1'b0, ciph_cnt} + 1'b1;

    // Data words ride the encrypt or the decrypt valid
    assign data_in  = i_encrypt_mode ? i_valid_encrypt : i_valid_decrypt;
    assign aad_left = (word_cnt < i_length_aad);

    //--------------------
    // GHASH input valids
    //--------------------
    // AAD always comes first, on the decrypt valid
    assign valid_aad  = i_enable & pkt_open & i_valid_decrypt & aad_left;
    assign valid_data = i_enable & pkt_open & data_in & ~aad_left & data_allowed
                        & ({1'b0, word_cnt} < total_len);
    assign ciph_inc   = i_enable & pkt_open & i_valid_encrypt & ~aad_left;

    assign last_aad = valid_aad & (word_cnt_nx == {1'b0, i_length_aad});

    // Encrypt mode closes on the cipher count, else on the total count
    assign last_data = i_encrypt_mode ?
                       (ciph_inc & (ciph_cnt_nx == {1'b0, i_length_plaintext})) :
                       (valid_data & (word_cnt_nx == total_len));

    //--------------------
    // Four cases by nonzero lengths
    //--------------------
    assign fsm_case = {|i_length_aad, |i_length_plaintext};

    always_comb
    begin
        case (fsm_case)
            // No AAD, no data: everything happens at sop
            2'b00:
            begin
                aad_complete = pkt_open;
                close_on_pre = 1'b1;
                data_allowed = 1'b0;
            end
            // AAD only, length word with the pre strobe
            2'b10:
            begin
                aad_complete = aad_done;
                close_on_pre = 1'b1;
                data_allowed = 1'b0;
            end
            // Data only
            2'b01:
            begin
                aad_complete = pkt_open;
                close_on_pre = 1'b0;
                data_allowed = 1'b1;
            end
            default:
            begin
                aad_complete = aad_done;
                close_on_pre = 1'b0;
                data_allowed = 1'b1;
            end
        endcase
    end

    //--------------------
    // GCTR strobes, once per packet
    //--------------------
    // Cycle after last AAD word, or at sop without AAD
    assign sop_pre  = i_enable & pkt_open & aad_complete & ~pre_fired;
    // First data word
    assign data_sop = valid_data & ~sop_fired;
    assign trig     = i_enable & i_trigger_pre_block;

    // Length word closes the packet
    assign valid_length = i_enable & pkt_open &
                          (close_on_pre ? (aad_complete & ~pre_fired) : len_pend);

    //--------------------
    // State update
    //--------------------
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            word_cnt_q  <= '0;
            ciph_cnt_q  <= '0;
            open_q      <= 1'b0;
            aad_done_q  <= 1'b0;
            pre_fired_q <= 1'b0;
            sop_fired_q <= 1'b0;
            len_pend_q  <= 1'b0;
        end
        else
        begin
            if (valid_aad || valid_data)
                word_cnt_q <= word_cnt_nx[NB_TIMER-1:0];
            else
                word_cnt_q <= word_cnt;
            if (ciph_inc)
                ciph_cnt_q <= ciph_cnt_nx[NB_TIMER-1:0];
            else
                ciph_cnt_q <= ciph_cnt;
            // Sticky flags, cleared only by a new sop
            aad_done_q  <= aad_done | last_aad;
            pre_fired_q <= pre_fired | sop_pre;
            sop_fired_q <= sop_fired | data_sop;
            // Pending length waits out low-enable cycles
            len_pend_q  <= (len_pend | last_data) & ~valid_length;
            open_q      <= pkt_open & ~valid_length;
        end
    end

    //--------------------
    // Outputs
    //--------------------
    assign o_strobe.sop          = en_sop;
    assign o_strobe.valid_aad    = valid_aad;
    assign o_strobe.valid_data   = valid_data;
    assign o_strobe.valid_length = valid_length;

    // A pre-block trigger also counts as a pre sop
    assign o_mark.sop_pre       = sop_pre | trig;
    assign o_mark.sop           = data_sop;
    assign o_mark.triggered_pre = trig;

    assign o_data_sop = sop_pre;

endmodule

// File: gcm_types_pkg.sv
//--------------------
// GHASH kind enum and the packed structs
// passed between control blocks
//--------------------

package gcm_types_pkg;

    import gcm_cfg_pkg::*;

    // What the GHASH operand carries
    typedef enum logic [NB_KIND-1:0]
    {
        NONE = 2'd0,
        AAD  = 2'd1,
        DATA = 2'd2,
        LEN  = 2'd3
    } ghash_kind_t;

    // Registered GHASH operand, 132 bits
    typedef struct packed
    {
        logic                sop;
        logic                valid;
        ghash_kind_t         kind;
        logic [NB_BLOCK-1:0] data;
    } ghash_word_t;

    // GCTR marks sent through the AES latency line
    typedef struct packed
    {
        logic sop_pre;
        logic sop;
        logic triggered_pre;
    } gctr_mark_t;

    // FSM to GHASH selector, combinational
    typedef struct packed
    {
        logic sop;
        logic valid_aad;
        logic valid_data;
        logic valid_length;
    } ghash_strobe_t;

endpackage

// File: tb_gcm_ctrl_top.sv
//--------------------
// Testbench for the GCM control top:
// packet table, clock, reset, timeout
//--------------------

`timescale 1ns/1ps

module tb_gcm_ctrl_top
    import gcm_cfg_pkg::*;
    import gcm_types_pkg::*;
();

    localparam int NUM_PKT    = 6;
    localparam int RST_CYCLES = 16;
    localparam int MARGIN     = 16;
    localparam int DRIVE_DLY  = 1;

    // One packet, stimulus and expected results
    typedef struct packed
    {
        logic [NB_TIMER-1:0] len_aad;
        logic [NB_TIMER-1:0] len_pt;
        logic                encrypt;
        logic                trigger;
        logic [NB_IV-1:0]    iv;
        logic [NB_TIMER-1:0] exp_aad;
        logic [NB_TIMER-1:0] exp_data;
        logic [NB_BLOCK-1:0] exp_len_word;
    } pkt_entry_t;

    //--------------------
    // DUT and monitor wiring
    //--------------------
    logic                clock;
    logic                rst;
    logic                enable;
    logic                sop;
    logic                valid_encrypt;
    logic                valid_decrypt;
    logic                encrypt_mode;
    logic                trigger_pre_block;
    logic [NB_TIMER-1:0] length_aad;
    logic [NB_TIMER-1:0] length_plaintext;
    logic [NB_BLOCK-1:0] word;
    logic [NB_IV-1:0]    iv;
    ghash_word_t         ghash;
    gctr_mark_t          gctr_mark;
    logic [NB_BLOCK-1:0] ctr_block;
    logic [NB_TIMER-1:0] exp_aad;
    logic [NB_TIMER-1:0] exp_data;
    logic [NB_BLOCK-1:0] exp_len_word;
    int                  mon_errors;
    int                  mon_packets;

    pkt_entry_t pkt_table [NUM_PKT];
    integer     seed = 32'h8794ac4b;
    int         cycle_cnt = 0;
    int         cycle_limit;
    int         tb_errors = 0;

    gcm_ctrl_top gcm_ctrl_top_i
    (
        .i_clock             (clock),
        .i_rst               (rst),
        .i_enable            (enable),
        .i_sop               (sop),
        .i_valid_encrypt     (valid_encrypt),
        .i_valid_decrypt     (valid_decrypt),
        .i_encrypt_mode      (encrypt_mode),
        .i_trigger_pre_block (trigger_pre_block),
        .i_length_aad        (length_aad),
        .i_length_plaintext  (length_plaintext),
        .i_word              (word),
        .i_iv                (iv),
        .o_ghash             (ghash),
        .o_gctr_mark         (gctr_mark),
        .o_ctr_block         (ctr_block)
    );

    gcm_ctrl_monitor ctrl_monitor_i
    (
        .i_clock             (clock),
        .i_rst               (rst),
        .i_enable            (enable),
        .i_sop               (sop),
        .i_valid_encrypt     (valid_encrypt),
        .i_valid_decrypt     (valid_decrypt),
        .i_encrypt_mode      (encrypt_mode),
        .i_trigger_pre_block (trigger_pre_block),
        .i_length_aad        (length_aad),
        .i_length_plaintext  (length_plaintext),
        .i_word              (word),
        .i_iv                (iv),
        .i_ghash             (ghash),
        .i_gctr_mark         (gctr_mark),
        .i_ctr_block         (ctr_block),
        .i_exp_aad           (exp_aad),
        .i_exp_data          (exp_data),
        .i_exp_len_word      (exp_len_word),
        .o_errors            (mon_errors),
        .o_packets           (mon_packets)
    );

    // Strobe assertions inside the FSM
    bind gcm_seq_fsm gcm_ctrl_checker seq_checker_i
    (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_enable   (i_enable),
        .i_sop      (i_sop),
        .i_strobe   (o_strobe),
        .i_data_sop (o_data_sop)
    );

    //--------------------
    // Clock and watchdog
    //--------------------
    initial
    begin
        clock = 1'b0;
    end

    always #4 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // One packet: sop, AAD words, data words, then wait for the LEN word
    task automatic run_packet(input pkt_entry_t p);
        int start_cnt;
        int total;
        start_cnt         = mon_packets;
        total             = p.len_aad + p.len_pt;
        length_aad        = p.len_aad;
        length_plaintext  = p.len_pt;
        encrypt_mode      = p.encrypt;
        iv                = p.iv;
        exp_aad           = p.exp_aad;
        exp_data          = p.exp_data;
        exp_len_word      = p.exp_len_word;
        sop               = 1'b1;
        trigger_pre_block = p.trigger;
        @(posedge clock);
        #DRIVE_DLY;
        sop               = 1'b0;
        trigger_pre_block = 1'b0;
        for (int w = 0; w < total; w++)
        begin
            // Random low-enable gap
            if (($random(seed) & 3) == 0)
            begin
                enable = 1'b0;
                @(posedge clock);
                #DRIVE_DLY;
                enable = 1'b1;
            end
            word = {$random(seed), $random(seed), $random(seed), $random(seed)};
            if (w < p.len_aad)
                valid_decrypt = 1'b1;
            else if (p.encrypt)
                valid_encrypt = 1'b1;
            else
                valid_decrypt = 1'b1;
            @(posedge clock);
            #DRIVE_DLY;
            valid_decrypt = 1'b0;
            valid_encrypt = 1'b0;
        end
        while (mon_packets == start_cnt)
            @(posedge clock);
        #DRIVE_DLY;
    endtask

    //--------------------
    // Stimulus
    //--------------------
    initial
    begin
        int total_err;
        rst               = 1'b1;
        enable            = 1'b0;
        sop               = 1'b0;
        valid_encrypt     = 1'b0;
        valid_decrypt     = 1'b0;
        encrypt_mode      = 1'b0;
        trigger_pre_block = 1'b0;
        length_aad        = '0;
        length_plaintext  = '0;
        word              = '0;
        iv                = '0;
        exp_aad           = '0;
        exp_data          = '0;
        exp_len_word      = '0;

        // AAD, data, mode, trigger, IV, then expected counts and length word
        pkt_table[0] = '{len_aad: 2, len_pt: 3, encrypt: 1, trigger: 0,
                         iv: 96'h0123456789abcdef00112233, exp_aad: 2, exp_data: 3,
                         exp_len_word: {64'd256, 64'd384}};
        pkt_table[1] = '{len_aad: 0, len_pt: 4, encrypt: 0, trigger: 1,
                         iv: 96'h44556677_8899aabb_ccddeeff, exp_aad: 0, exp_data: 4,
                         exp_len_word: {64'd0, 64'd512}};
        pkt_table[2] = '{len_aad: 3, len_pt: 0, encrypt: 1, trigger: 1,
                         iv: 96'h0f1e2d3c_4b5a6978_8796a5b4, exp_aad: 3, exp_data: 0,
                         exp_len_word: {64'd384, 64'd0}};
        pkt_table[3] = '{len_aad: 0, len_pt: 0, encrypt: 0, trigger: 0,
                         iv: 96'h13579bdf_2468ace0_fdb97531, exp_aad: 0, exp_data: 0,
                         exp_len_word: {64'd0, 64'd0}};
        pkt_table[4] = '{len_aad: 1, len_pt: 5, encrypt: 1, trigger: 0,
                         iv: 96'hffffffff_00000000_a5a5a5a5, exp_aad: 1, exp_data: 5,
                         exp_len_word: {64'd128, 64'd640}};
        pkt_table[5] = '{len_aad: 4, len_pt: 6, encrypt: 0, trigger: 1,
                         iv: 96'h600dcafe_12345678_9abcdef0, exp_aad: 4, exp_data: 6,
                         exp_len_word: {64'd512, 64'd768}};

        // Gaps can double each word, plus pipeline and margin per packet
        cycle_limit = RST_CYCLES + AES_LATENCY + MARGIN;
        foreach (pkt_table[i])
            cycle_limit += 2 * (pkt_table[i].len_aad + pkt_table[i].len_pt)
                           + AES_LATENCY + MARGIN;

        // Enable high for the second half of reset
        repeat (RST_CYCLES / 2) @(posedge clock);
        #DRIVE_DLY;
        enable = 1'b1;
        repeat (RST_CYCLES - RST_CYCLES / 2) @(posedge clock);
        #DRIVE_DLY;
        rst    = 1'b0;

        foreach (pkt_table[i])
            run_packet(pkt_table[i]);

        // Let the last marks leave the AES latency line
        repeat (AES_LATENCY + 4) @(posedge clock);
        #DRIVE_DLY;

        if (mon_packets != NUM_PKT)
        begin
            $display("wrong number of packets closed: %0d LEN words, %0d packets sent",
                     mon_packets, NUM_PKT);
            tb_errors++;
        end

        total_err = mon_errors + gcm_ctrl_top_i.u_seq_fsm.seq_checker_i.assert_errors
                    + tb_errors;
        $display("errors: monitor=%0d checker=%0d testbench=%0d", mon_errors,
                 gcm_ctrl_top_i.u_seq_fsm.seq_checker_i.assert_errors, tb_errors);
        if (total_err == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
